/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_audio_out
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/10ps
PASS_MSG  ?= Simulation completed successfully

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/audio_out_top.sv */
`timescale 1ns/10ps
`include "audio_settings.svh"

module audio_out_top (
    input  logic                            clk245760,
    input  logic                            rst,
    input  logic [`AUDIO_SAMPLE_WIDTH-1:0]  sample_i,
    input  audio_pkg::channel_e             chan_i,
    input  logic                            sample_we_i,
    input  logic                            locked_i,
    output logic                            dac_mclk_o,
    output logic                            dac_bck_o,
    output logic                            dac_lrck_o,
    output logic                            dac_sda_o,
    output logic                            fifo_overflow_o,
    output logic                            led_locked_o
);

    logic                           rst_ip;
    logic [`AUDIO_SAMPLE_WIDTH-1:0] fifo_sample;
    audio_pkg::channel_e            fifo_chan;
    logic                           fifo_valid;
    logic                           fifo_pop;
    logic [`AUDIO_SAMPLE_WIDTH-1:0] pair_left;
    logic [`AUDIO_SAMPLE_WIDTH-1:0] pair_right;
    logic                           pair_ready;
    logic                           pair_load;

    // master clock straight from the system clock
    assign dac_mclk_o   = clk245760;
    assign led_locked_o = locked_i;

    rst_stretch rst_stretch_i (
        .clk245760 (clk245760),
        .rst       (rst),
        .rst_ip_o  (rst_ip)
    );

    sample_fifo sample_fifo_i (
        .clk245760  (clk245760),
        .rst        (rst_ip),
        .we_i       (sample_we_i),
        .sample_i   (sample_i),
        .chan_i     (chan_i),
        .pop_i      (fifo_pop),
        .sample_o   (fifo_sample),
        .chan_o     (fifo_chan),
        .valid_o    (fifo_valid),
        .overflow_o (fifo_overflow_o)
    );

    stereo_pair stereo_pair_i (
        .clk245760    (clk245760),
        .rst          (rst_ip),
        .locked_i     (locked_i),
        .sample_i     (fifo_sample),
        .chan_i       (fifo_chan),
        .valid_i      (fifo_valid),
        .pop_o        (fifo_pop),
        .load_i       (pair_load),
        .left_o       (pair_left),
        .right_o      (pair_right),
        .pair_ready_o (pair_ready)
    );

    i2s_tx i2s_tx_i (
        .clk245760    (clk245760),
        .rst          (rst_ip),
        .left_i       (pair_left),
        .right_i      (pair_right),
        .pair_ready_i (pair_ready),
        .load_o       (pair_load),
        .bck_o        (dac_bck_o),
        .lrck_o       (dac_lrck_o),
        .sda_o        (dac_sda_o)
    );

endmodule

/* hdl/audio_pkg.sv */
package audio_pkg;

    // channel tag of a sample, also the word-clock level
    typedef enum logic {
        CH_LEFT  = 1'b0,
        CH_RIGHT = 1'b1
    } channel_e;

endpackage

/* hdl/audio_settings.svh */
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// bits per audio sample
`define AUDIO_SAMPLE_WIDTH 24

// sample FIFO holds 2**4 entries
`define AUDIO_FIFO_DEPTH_LOG2 4

// cycles of internal reset after rst falls
`define AUDIO_RST_STRETCH 32

// system clocks per bit clock, must be even
`define AUDIO_BCK_DIV 4

// bit clocks per channel slot
`define AUDIO_SLOT_BITS 32

`endif

/* hdl/i2s_tx.sv */
`timescale 1ns/10ps
`include "audio_settings.svh"

module i2s_tx (
    input  logic                            clk245760,
    input  logic                            rst,
    input  logic [`AUDIO_SAMPLE_WIDTH-1:0]  left_i,
    input  logic [`AUDIO_SAMPLE_WIDTH-1:0]  right_i,
    input  logic                            pair_ready_i,
    output logic                            load_o,
    output logic                            bck_o,
    output logic                            lrck_o,
    output logic                            sda_o
);

    localparam int W          = `AUDIO_SAMPLE_WIDTH;
    localparam int DIV        = `AUDIO_BCK_DIV;
    localparam int SLOT       = `AUDIO_SLOT_BITS;
    localparam int FRAME_BITS = 2 * SLOT;
    localparam int DW         = $clog2(DIV);
    localparam int BW         = $clog2(FRAME_BITS);

    logic [DW-1:0]         div_cnt;
    logic [BW-1:0]         bit_cnt;
    logic [BW-1:0]         bit_next;
    logic                  bit_end;
    logic                  frame_end;
    audio_pkg::channel_e   lrck_q;
    logic [W-1:0]          hold_left;
    logic [W-1:0]          hold_right;
    logic [W-1:0]          next_left;
    logic [W-1:0]          next_right;
    logic [FRAME_BITS-1:0] shift_q;

    assign bit_next  = bit_cnt + 1'b1;
    assign bit_end   = (div_cnt == DW'(DIV - 1));
    assign frame_end = bit_end && (bit_cnt == BW'(FRAME_BITS - 1));
    assign load_o    = frame_end;

    // underrun plays the held pair again
    assign next_left  = pair_ready_i ? left_i : hold_left;
    assign next_right = pair_ready_i ? right_i : hold_right;

    always_ff @(posedge clk245760) begin
        if (rst) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            bck_o   <= 1'b0;
        end else begin
            div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
            if (bit_end) begin
                bit_cnt <= bit_next;
            end
            // bck high for the second half of each bit
            if (div_cnt == DW'(DIV / 2 - 1)) begin
                bck_o <= 1'b1;
            end else if (bit_end) begin
                bck_o <= 1'b0;
            end
        end
    end

    // lrck and data change with the falling bck edge
    always_ff @(posedge clk245760) begin
        if (rst) begin
            lrck_q     <= audio_pkg::CH_LEFT;
            sda_o      <= 1'b0;
            hold_left  <= '0;
            hold_right <= '0;
            shift_q    <= '0;
        end else if (bit_end) begin
            lrck_q <= bit_next[BW-1] ? audio_pkg::CH_RIGHT : audio_pkg::CH_LEFT;
            // msb lands one bit after the word-clock edge
            sda_o  <= shift_q[FRAME_BITS-1];
            if (frame_end) begin
                hold_left  <= next_left;
                hold_right <= next_right;
                shift_q    <= {next_left, {(SLOT - W){1'b0}},
                               next_right, {(SLOT - W){1'b0}}};
            end else begin
                shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
            end
        end
    end

    assign lrck_o = (lrck_q == audio_pkg::CH_RIGHT);

    lrck_on_bck_fall: assert property (@(posedge clk245760) disable iff (rst)
        $changed(lrck_o) |-> $fell(bck_o));

endmodule

/* hdl/rst_stretch.sv */
`timescale 1ns/10ps
`include "audio_settings.svh"

module rst_stretch (
    input  logic clk245760,
    input  logic rst,
    output logic rst_ip_o
);

    localparam int N  = `AUDIO_RST_STRETCH;
    localparam int CW = $clog2(N + 1);

    logic [CW-1:0] cnt;

    // saturating count of cycles since rst fell
    always_ff @(posedge clk245760) begin
        if (rst) begin
            cnt      <= '0;
            rst_ip_o <= 1'b1;
        end else begin
            if (cnt != CW'(N)) begin
                cnt <= cnt + 1'b1;
            end
            // output register adds the last cycle
            rst_ip_o <= (cnt < CW'(N - 1));
        end
    end

    // internal reset ends N cycles after the last rst cycle
    rst_stretch_len: assert property (@(posedge clk245760)
        $fell(rst_ip_o) |-> $past(rst, N + 1) && !$past(rst, N));

endmodule

/* hdl/sample_fifo.sv */
`timescale 1ns/10ps
`include "audio_settings.svh"

module sample_fifo (
    input  logic                            clk245760,
    input  logic                            rst,
    input  logic                            we_i,
    input  logic [`AUDIO_SAMPLE_WIDTH-1:0]  sample_i,
    input  audio_pkg::channel_e             chan_i,
    input  logic                            pop_i,
    output logic [`AUDIO_SAMPLE_WIDTH-1:0]  sample_o,
    output audio_pkg::channel_e             chan_o,
    output logic                            valid_o,
    output logic                            overflow_o
);

    localparam int AW    = `AUDIO_FIFO_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;
    localparam int W     = `AUDIO_SAMPLE_WIDTH;

    logic [W-1:0]        sample_mem [DEPTH];
    audio_pkg::channel_e chan_mem   [DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [AW:0]         count;
    logic                full;
    logic                push;

    assign full = (count == (AW + 1)'(DEPTH));
    // writes into a full FIFO are lost
    assign push = we_i && !full;

    always_ff @(posedge clk245760) begin
        if (push) begin
            sample_mem[wr_ptr] <= sample_i;
            chan_mem[wr_ptr]   <= chan_i;
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset
            if (we_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    // show-ahead head entry
    assign sample_o = sample_mem[rd_ptr];
    assign chan_o   = chan_mem[rd_ptr];
    assign valid_o  = (count != '0);

    no_pop_when_empty: assert property (@(posedge clk245760) disable iff (rst)
        pop_i |-> valid_o);

endmodule

/* hdl/stereo_pair.sv */
`timescale 1ns/10ps
`include "audio_settings.svh"

module stereo_pair (
    input  logic                            clk245760,
    input  logic                            rst,
    input  logic                            locked_i,
    input  logic [`AUDIO_SAMPLE_WIDTH-1:0]  sample_i,
    input  audio_pkg::channel_e             chan_i,
    input  logic                            valid_i,
    output logic                            pop_o,
    input  logic                            load_i,
    output logic [`AUDIO_SAMPLE_WIDTH-1:0]  left_o,
    output logic [`AUDIO_SAMPLE_WIDTH-1:0]  right_o,
    output logic                            pair_ready_o
);

    logic [`AUDIO_SAMPLE_WIDTH-1:0] left_q;
    logic [`AUDIO_SAMPLE_WIDTH-1:0] right_q;
    logic                           ready_q;

    // pending pair blocks the FIFO, unless unlocked
    assign pop_o = valid_i && (!ready_q || !locked_i);

    always_ff @(posedge clk245760) begin
        if (rst) begin
            left_q  <= '0;
            right_q <= '0;
            ready_q <= 1'b0;
        end else if (!locked_i) begin
            // mute, samples popped here are discarded
            left_q  <= '0;
            right_q <= '0;
            ready_q <= 1'b1;
        end else begin
            if (load_i) begin
                ready_q <= 1'b0;
            end
            if (pop_o) begin
                if (chan_i == audio_pkg::CH_LEFT) begin
                    left_q <= sample_i;
                end else begin
                    // right word completes the pair
                    right_q <= sample_i;
                    ready_q <= 1'b1;
                end
            end
        end
    end

    assign left_o       = left_q;
    assign right_o      = right_q;
    assign pair_ready_o = ready_q;

    // a waiting pair stays put until the serializer takes it
    pair_held_until_load: assert property (@(posedge clk245760) disable iff (rst)
        locked_i && pair_ready_o && !load_i
        |=> pair_ready_o && $stable(left_o) && $stable(right_o));

endmodule

/* sim.f */
+incdir+hdl
hdl/audio_pkg.sv
hdl/rst_stretch.sv
hdl/sample_fifo.sv
hdl/stereo_pair.sv
hdl/i2s_tx.sv
hdl/audio_out_top.sv
tests/tb_clock.sv
tests/tb_audio_out.sv

/* tests/tb_audio_out.sv */
`timescale 1ns/10ps
`include "audio_settings.svh"

module tb_audio_out;

    localparam int W         = `AUDIO_SAMPLE_WIDTH;
    localparam int FIFO_SIZE = 1 << `AUDIO_FIFO_DEPTH_LOG2;
    localparam int HALF      = `AUDIO_SLOT_BITS * `AUDIO_BCK_DIV;

    logic                clk245760;
    logic                rst;
    logic [W-1:0]        sample_i;
    audio_pkg::channel_e chan_i;
    logic                sample_we_i;
    logic                locked_i;
    logic                dac_mclk_o;
    logic                dac_bck_o;
    logic                dac_lrck_o;
    logic                dac_sda_o;
    logic                fifo_overflow_o;
    logic                led_locked_o;

    // reference model state
    logic [2*W-1:0] pair_q [$];
    int             elig_q [$];
    logic [2*W-1:0] last_pair;
    logic [W-1:0]   pend_left;
    logic           pend_valid;
    logic           model_locked;
    int             frames_done;
    int             errors;
    int             timeouts;
    logic           timed_out;

    // serial decoder state
    logic           bck_prev;
    logic           lrck_prev;
    logic [31:0]    shift_w;
    logic           cap_pend;
    logic [W-1:0]   left_w;
    int             half_cnt;
    logic           half_seen;
    int             rst_low_cnt;
    int             clk_count;

    tb_clock clock_gen_i (
        .clk_o (clk245760),
        .rst_o (rst)
    );

    audio_out_top dut_i (
        .clk245760       (clk245760),
        .rst             (rst),
        .sample_i        (sample_i),
        .chan_i          (chan_i),
        .sample_we_i     (sample_we_i),
        .locked_i        (locked_i),
        .dac_mclk_o      (dac_mclk_o),
        .dac_bck_o       (dac_bck_o),
        .dac_lrck_o      (dac_lrck_o),
        .dac_sda_o       (dac_sda_o),
        .fifo_overflow_o (fifo_overflow_o),
        .led_locked_o    (led_locked_o)
    );

    task automatic fail_value(string name, logic [63:0] got, logic [63:0] exp);
        errors++;
        $display("Fail %s: got %0h expected %0h", name, got, exp);
    endtask

    // FIFO order, drop when full, right word completes a pair
    task automatic model_write(audio_pkg::channel_e ch, logic [W-1:0] val);
        int held;
        held = 2 * pair_q.size() + (pend_valid ? 1 : 0);
        // FIFO plus the two words the pair stage absorbs
        if (!model_locked || held >= FIFO_SIZE + 2) begin
            return;
        end
        if (ch == audio_pkg::CH_LEFT) begin
            pend_left  = val;
            pend_valid = 1'b1;
        end else begin
            pair_q.push_back({pend_left, val});
            elig_q.push_back(frames_done + 1);
            pend_valid = 1'b0;
        end
    endtask

    task automatic write_sample(audio_pkg::channel_e ch, logic [W-1:0] val);
        @(posedge clk245760);
        sample_i    <= val;
        chan_i      <= ch;
        sample_we_i <= 1'b1;
        model_write(ch, val);
    endtask

    task automatic write_pairs(int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = $urandom();
            write_sample(audio_pkg::CH_LEFT, r[W-1:0]);
            r = $urandom();
            write_sample(audio_pkg::CH_RIGHT, r[W-1:0]);
        end
        @(posedge clk245760);
        sample_we_i <= 1'b0;
    endtask

    // a muted zero pair is pending both after lock drops and when it returns
    task automatic set_lock(logic level);
        @(posedge clk245760);
        locked_i <= level;
        pair_q.push_back('0);
        elig_q.push_back(frames_done + 1);
        pend_left    = '0;
        pend_valid   = 1'b0;
        model_locked = level;
    endtask

    task automatic wait_frames(int n);
        int target;
        int cycles;
        target = frames_done + n;
        cycles = 0;
        if (timed_out) begin
            return;
        end
        while (frames_done < target && cycles < (n + 2) * 2 * HALF) begin
            @(negedge clk245760);
            cycles++;
        end
        if (frames_done < target) begin
            timed_out = 1'b1;
            timeouts++;
            $display("timeout: decoder saw no new DAC frame for %0d cycles", cycles);
        end
    endtask

    task automatic wait_overflow();
        int cycles;
        cycles = 0;
        if (timed_out) begin
            return;
        end
        while (!fifo_overflow_o && cycles < 64) begin
            @(negedge clk245760);
            cycles++;
        end
        if (!fifo_overflow_o) begin
            timed_out = 1'b1;
            timeouts++;
            $display("timeout: FIFO overflow flag never went high");
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst && cycles < 16) begin
            @(negedge clk245760);
            cycles++;
        end
        if (rst) begin
            timed_out = 1'b1;
            timeouts++;
            $display("timeout: reset was never released");
        end
    endtask

    task automatic expect_drained(string phase);
        drained: assert (pair_q.size() == 0) else begin
            errors++;
            $display("%s: %0d written pairs were never played", phase, pair_q.size());
        end
    endtask

    // frame j plays the next queued pair once eligible, else repeats the last one
    task automatic check_frame(logic [W-1:0] left, logic [W-1:0] right);
        logic [2*W-1:0] exp_pair;
        exp_pair = last_pair;
        if (pair_q.size() > 0 && elig_q[0] <= frames_done) begin
            exp_pair = pair_q.pop_front();
            elig_q.delete(0);
        end
        left_word: assert (left == exp_pair[2*W-1 -: W])
            else fail_value("dac_sda_o left word", left, exp_pair[2*W-1 -: W]);
        right_word: assert (right == exp_pair[W-1:0])
            else fail_value("dac_sda_o right word", right, exp_pair[W-1:0]);
        last_pair = exp_pair;
        frames_done++;
    endtask

    // I2S decoder, a slot ends one bit clock after the word-clock edge
    always @(posedge clk245760) begin : decode
        logic [31:0] word;
        if (rst) begin
            bck_prev  = 1'b0;
            lrck_prev = 1'b0;
            shift_w   = '0;
            cap_pend  = 1'b0;
            half_cnt  = 0;
            half_seen = 1'b0;
        end else begin
            half_cnt = half_cnt + 1;
            if (dac_lrck_o != lrck_prev) begin
                if (half_seen) begin
                    half_len: assert (half_cnt == HALF)
                        else fail_value("dac_lrck_o half period", half_cnt, HALF);
                end
                half_seen = 1'b1;
                half_cnt  = 0;
                cap_pend  = 1'b1;
                lrck_prev = dac_lrck_o;
            end
            if (dac_bck_o && !bck_prev) begin
                word    = {shift_w[30:0], dac_sda_o};
                shift_w = word;
                if (cap_pend) begin
                    cap_pend = 1'b0;
                    pad_zero: assert (word[31-W:0] == '0)
                        else fail_value("dac_sda_o pad bits", word[31-W:0], 0);
                    // slot that ran while lrck was low is the left one
                    if (lrck_prev) begin
                        left_w = word[31 -: W];
                    end else begin
                        check_frame(left_w, word[31 -: W]);
                    end
                end
            end
            bck_prev = dac_bck_o;
        end
    end

    // outputs quiet during reset and the stretch that follows it
    always @(posedge clk245760) begin : reset_window
        if (rst) begin
            rst_low_cnt = 0;
        end else if (rst_low_cnt < 1000) begin
            rst_low_cnt++;
        end
        if (clk_count >= 2 && (rst || rst_low_cnt <= `AUDIO_RST_STRETCH)) begin
            quiet_outputs: assert ({dac_bck_o, dac_lrck_o, dac_sda_o, fifo_overflow_o} == 4'b0)
                else fail_value("dac outputs in reset",
                                {dac_bck_o, dac_lrck_o, dac_sda_o, fifo_overflow_o}, 0);
        end
        clk_count++;
    end

    // master clock copies the system clock in both phases
    always @(posedge clk245760 or negedge clk245760) begin : mclk_check
        #1;
        mclk_follows_clk: assert (dac_mclk_o == clk245760)
            else fail_value("dac_mclk_o", dac_mclk_o, clk245760);
    end

    led_follows_lock: assert property (@(posedge clk245760) led_locked_o == locked_i)
        else begin
            errors++;
            $display("Fail led_locked_o: got %0h expected %0h", led_locked_o, locked_i);
        end

    overflow_sticky: assert property (@(posedge clk245760) disable iff (rst)
        fifo_overflow_o |=> fifo_overflow_o)
        else begin
            errors++;
            $display("Fail fifo_overflow_o: got 0 expected 1");
        end

    initial begin
        sample_i     = '0;
        chan_i       = audio_pkg::CH_LEFT;
        sample_we_i  = 1'b0;
        locked_i     = 1'b1;
        last_pair    = '0;
        pend_left    = '0;
        pend_valid   = 1'b0;
        model_locked = 1'b1;
        frames_done  = 0;
        errors       = 0;
        timeouts     = 0;
        timed_out    = 1'b0;
        rst_low_cnt  = 0;
        clk_count    = 0;
        void'($urandom(44994));

        wait_reset_release();
        wait_frames(2);

        write_pairs(8);
        wait_frames(11);
        no_early_overflow: assert (fifo_overflow_o == 1'b0)
            else fail_value("fifo_overflow_o", fifo_overflow_o, 0);
        expect_drained("ordered playback");

        // underrun, repeats checked frame by frame
        wait_frames(3);

        write_pairs(12);
        wait_overflow();
        wait_frames(12);
        expect_drained("overflow burst");

        set_lock(1'b0);
        write_pairs(2);
        wait_frames(4);
        set_lock(1'b1);
        write_pairs(4);
        wait_frames(8);
        expect_drained("lock recovery");

        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset held for two rising edges
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule
